//--- common/alu_pkg.sv
/*
 * shared definitions of the integer ALU
 * data widths, result select codes, comparator bits,
 * co-processor slot indices, function codes and timeout width
 */
`default_nettype none

package alu_pkg;

    // widths ------------------------------------
    localparam int XLEN    = 32;           // data path width
    localparam int SHAMT_W = 5;            // shift amount width

    // result select, bit 0 set means subtract in the adder
    typedef enum logic [2:0] {
        ALU_OP_ADD  = 3'b000,              // opa + opb
        ALU_OP_SUB  = 3'b001,              // opa - opb
        ALU_OP_CP   = 3'b010,              // merged co-processor result
        ALU_OP_SLT  = 3'b011,              // set if less than
        ALU_OP_MOVB = 3'b100,              // pass operand b
        ALU_OP_XOR  = 3'b101,
        ALU_OP_OR   = 3'b110,
        ALU_OP_AND  = 3'b111
    } alu_op_t;

    // comparator status bits
    localparam int CMP_EQ = 0;             // rs1 == rs2
    localparam int CMP_LT = 1;             // rs1 < rs2

    // co-processor slots ------------------------
    localparam int CP_SLOTS     = 3;       // trigger width
    localparam int CP_SEL_SHIFT = 0;       // iterative shifter
    localparam int CP_SEL_COND  = 1;       // conditional zero
    localparam int CP_SEL_RSVD  = 2;       // reserved multiplier slot, nobody answers

    // function codes overlap, only the started unit decodes them
    typedef logic [1:0] cp_funct_t;
    localparam cp_funct_t CP_SLL       = 2'b00;
    localparam cp_funct_t CP_SRL       = 2'b01;
    localparam cp_funct_t CP_SRA       = 2'b10;
    localparam cp_funct_t CP_CZERO_EQZ = 2'b00;
    localparam cp_funct_t CP_CZERO_NEZ = 2'b01;

    localparam int CP_TIMEOUT_W = 6;       // run counter width, timeout near 57 cycles

endpackage

`default_nettype wire

//--- common/cp_if.sv
/*
 * link between the co-processor controller and one co-processor
 * start/valid pulse handshake, result is zero outside the valid cycle
 */
`timescale 1ns/1ps
`default_nettype none

interface cp_if import alu_pkg::*; ();

    logic            start;    // one-cycle trigger
    cp_funct_t       funct;    // unit specific function code
    logic [XLEN-1:0] rs1;      // first operand
    logic [XLEN-1:0] opb;      // rs2 or immediate
    logic [XLEN-1:0] res;      // result, zero unless valid
    logic            valid;    // one-cycle done pulse

    // controller side
    modport ctrl (output start, funct, rs1, opb, input res, valid);

    // co-processor side
    modport unit (input start, funct, rs1, opb, output res, valid);

endinterface

`default_nettype wire

//--- adder/prefix_adder.sv
/*
 * parallel-prefix adder/subtractor on 33 bits
 * optional sign extension, five prefix levels and a carry-in level
 * bit 32 of the sum is the less-than answer
 */
`timescale 1ns/1ps
`default_nettype none

module prefix_adder import alu_pkg::*; (
    input  logic [XLEN-1:0] opa_i,        // operand a
    input  logic [XLEN-1:0] opb_i,        // operand b
    input  logic            sub_i,        // subtract: invert b, carry in 1
    input  logic            unsigned_i,   // zero-extend instead of sign-extend
    output logic [XLEN:0]   sum_o         // 33-bit sum
);

    logic [XLEN:0]   opa_x;               // extended a
    logic [XLEN:0]   opb_x;               // extended, maybe inverted b
    logic [XLEN:0]   carry;               // carry into each bit

    // group generate/propagate per prefix level, level 0 is bitwise
    logic [XLEN-1:0] gen_l [0:$clog2(XLEN)];
    logic [XLEN-1:0] prp_l [0:$clog2(XLEN)];

    // operand extension -------------------------
    assign opa_x = {opa_i[XLEN-1] & ~unsigned_i, opa_i};
    assign opb_x = {opb_i[XLEN-1] & ~unsigned_i, opb_i} ^ {(XLEN+1){sub_i}};

    // prefix tree -------------------------------
    always_comb begin : prefix_tree
        gen_l[0] = opa_x[XLEN-1:0] & opb_x[XLEN-1:0];   // bit generate
        prp_l[0] = opa_x[XLEN-1:0] ^ opb_x[XLEN-1:0];   // bit propagate
        // distance doubles per level: 1, 2, 4, 8, 16
        for (int lvl = 1; lvl <= $clog2(XLEN); lvl++) begin
            for (int i = 0; i < XLEN; i++) begin
                if (i >= (1 << (lvl - 1))) begin
                    gen_l[lvl][i] = gen_l[lvl-1][i] |
                                    (prp_l[lvl-1][i] & gen_l[lvl-1][i - (1 << (lvl - 1))]);
                    prp_l[lvl][i] = prp_l[lvl-1][i] & prp_l[lvl-1][i - (1 << (lvl - 1))];
                end else begin
                    gen_l[lvl][i] = gen_l[lvl-1][i];    // span already reaches bit 0
                    prp_l[lvl][i] = prp_l[lvl-1][i];
                end
            end
        end
    end : prefix_tree

    // final carry level -------------------------
    // group [i:0] either generates or passes the carry-in
    always_comb begin : carry_level
        carry[0] = sub_i;
        for (int i = 0; i < XLEN; i++) begin
            carry[i+1] = gen_l[$clog2(XLEN)][i] | (prp_l[$clog2(XLEN)][i] & sub_i);
        end
    end : carry_level

    assign sum_o = opa_x ^ opb_x ^ carry;     // top bit is sign of the 33-bit result

endmodule

`default_nettype wire

//--- src/alu_core.sv
/*
 * ALU data path
 * branch comparator, operand select and result select
 */
`timescale 1ns/1ps
`default_nettype none

module alu_core import alu_pkg::*; (
    input  alu_op_t         alu_op_i,     // result select
    input  logic            unsigned_i,   // unsigned compare / slt
    input  logic            opa_sel_i,    // 1: pc, 0: rs1
    input  logic            opb_sel_i,    // 1: imm, 0: rs2
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] cp_res_i,     // merged co-processor result
    output logic [1:0]      cmp_o,        // {lt, eq}
    output logic [XLEN-1:0] opb_o,        // selected b, co-processor operand
    output logic [XLEN-1:0] res_o,        // ALU result
    output logic [XLEN-1:0] add_o         // address output
);

    logic [XLEN:0]   cmp_rs1;             // extended for compare
    logic [XLEN:0]   cmp_rs2;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic [XLEN:0]   addsub;              // adder sum incl. sign bit

    // comparator --------------------------------
    assign cmp_rs1 = {rs1_i[XLEN-1] & ~unsigned_i, rs1_i};
    assign cmp_rs2 = {rs2_i[XLEN-1] & ~unsigned_i, rs2_i};

    assign cmp_o[CMP_EQ] = (rs1_i == rs2_i);
    assign cmp_o[CMP_LT] = ($signed(cmp_rs1) < $signed(cmp_rs2));  // one comparator for both

    // operand select
    assign opa   = opa_sel_i ? pc_i  : rs1_i;
    assign opb   = opb_sel_i ? imm_i : rs2_i;
    assign opb_o = opb;

    prefix_adder prefix_adder_inst (
        .opa_i      (opa        ),
        .opb_i      (opb        ),
        .sub_i      (alu_op_i[0]),        // set for sub and slt
        .unsigned_i (unsigned_i ),
        .sum_o      (addsub     )
    );

    assign add_o = addsub[XLEN-1:0];

    // result select -----------------------------
    always_comb begin : result_sel
        case (alu_op_i)
            ALU_OP_ADD  : res_o = addsub[XLEN-1:0];
            ALU_OP_SUB  : res_o = addsub[XLEN-1:0];
            ALU_OP_CP   : res_o = cp_res_i;            // zero unless done
            ALU_OP_SLT  : res_o = {{(XLEN-1){1'b0}}, addsub[XLEN]};
            ALU_OP_MOVB : res_o = opb;
            ALU_OP_XOR  : res_o = rs1_i ^ opb;
            ALU_OP_OR   : res_o = rs1_i | opb;
            ALU_OP_AND  : res_o = rs1_i & opb;
            default     : res_o = addsub[XLEN-1:0];
        endcase
    end : result_sel

endmodule

`default_nettype wire

//--- coproc/cp_control.sv
/*
 * co-processor control
 * start fan-out, result/done merge and run timeout monitor
 */
`timescale 1ns/1ps
`default_nettype none

module cp_control import alu_pkg::*; (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic [CP_SLOTS-1:0] cp_trig_i,    // one-hot start pulses
    input  cp_funct_t           cp_funct_i,
    input  logic                trap_i,       // aborts a running operation
    input  logic [XLEN-1:0]     rs1_i,
    input  logic [XLEN-1:0]     opb_i,
    cp_if.ctrl                  shift_cp,
    cp_if.ctrl                  cond_cp,
    output logic [XLEN-1:0]     cp_res_o,     // OR of unit results
    output logic                cp_done_o,    // OR of unit valids
    output logic                exc_o         // co-processor timeout
);

    logic                    any_trig;
    logic                    mon_run;     // operation in flight
    logic                    mon_fin;     // registered done
    logic [CP_TIMEOUT_W-1:0] mon_cnt;     // cycles since start

    // fan-out -----------------------------------
    assign shift_cp.start = cp_trig_i[CP_SEL_SHIFT];
    assign shift_cp.funct = cp_funct_i;
    assign shift_cp.rs1   = rs1_i;
    assign shift_cp.opb   = opb_i;

    assign cond_cp.start  = cp_trig_i[CP_SEL_COND];
    assign cond_cp.funct  = cp_funct_i;
    assign cond_cp.rs1    = rs1_i;
    assign cond_cp.opb    = opb_i;

    // idle units drive zero, so plain OR merges
    assign cp_res_o  = shift_cp.res | cond_cp.res;
    assign cp_done_o = shift_cp.valid | cond_cp.valid;

    // reserved slot still arms the monitor
    assign any_trig = cp_trig_i[CP_SEL_SHIFT] | cp_trig_i[CP_SEL_COND] | cp_trig_i[CP_SEL_RSVD];

    // run monitor -------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin : run_monitor
        if (!rstn_i) begin
            mon_run <= 1'b0;
            mon_fin <= 1'b0;
            mon_cnt <= '0;
            exc_o   <= 1'b0;
        end else begin
            exc_o   <= mon_run & (&mon_cnt[CP_TIMEOUT_W-1 -: 3]) & ~mon_fin;  // top 3 bits set
            mon_fin <= cp_done_o;
            if (!mon_run) begin
                mon_cnt <= '0;
                mon_run <= any_trig;
            end else begin
                mon_cnt <= mon_cnt + 1'b1;
                if (mon_fin || trap_i) begin  // done or aborted by trap
                    mon_run <= 1'b0;
                end
            end
        end
    end : run_monitor

endmodule

`default_nettype wire

//--- coproc/cp_shifter.sv
/*
 * bit-serial shifter co-processor
 * sll, srl and sra, one bit per cycle, done shamt+1 cycles after start
 */
`timescale 1ns/1ps
`default_nettype none

module cp_shifter import alu_pkg::*; (
    input  logic clk_i,
    input  logic rstn_i,
    cp_if.unit   cp
);

    logic               busy;             // shift in progress
    logic [SHAMT_W-1:0] cnt;              // bits left to shift
    logic [XLEN-1:0]    sreg;             // shift register
    cp_funct_t          funct_q;          // latched function
    logic               done;

    assign done = busy & (cnt == '0);

    // control -----------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin : shift_ctrl
        if (!rstn_i) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (cp.start && !busy) begin
            busy <= 1'b1;
            cnt  <= cp.opb[SHAMT_W-1:0];  // low bits of b are shamt
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt  <= cnt - 1'b1;
        end
    end : shift_ctrl

    // data --------------------------------------
    always_ff @(posedge clk_i) begin : shift_data
        if (cp.start && !busy) begin
            sreg    <= cp.rs1;
            funct_q <= cp.funct;
        end else if (busy && !done) begin
            case (funct_q)
                CP_SLL  : sreg <= {sreg[XLEN-2:0], 1'b0};
                CP_SRL  : sreg <= {1'b0, sreg[XLEN-1:1]};
                CP_SRA  : sreg <= {sreg[XLEN-1], sreg[XLEN-1:1]};  // keep sign
                default : sreg <= {1'b0, sreg[XLEN-1:1]};
            endcase
        end
    end : shift_data

    assign cp.valid = done;
    assign cp.res   = done ? sreg : '0;   // zero outside the done cycle

endmodule

`default_nettype wire

//--- coproc/cp_cond.sv
/*
 * conditional-zero co-processor, czero.eqz and czero.nez
 */
`timescale 1ns/1ps
`default_nettype none

module cp_cond import alu_pkg::*; (
    input  logic clk_i,
    input  logic rstn_i,
    cp_if.unit   cp
);

    logic            valid_q;
    logic [XLEN-1:0] res_q;
    logic            zero_out;            // force result to zero

    always_comb begin : cond_eval
        case (cp.funct)
            CP_CZERO_EQZ : zero_out = (cp.opb == '0);
            CP_CZERO_NEZ : zero_out = (cp.opb != '0);
            default      : zero_out = 1'b0;
        endcase
    end : cond_eval

    always_ff @(posedge clk_i or negedge rstn_i) begin : cond_valid
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cp.start;          // fixed one-cycle latency
        end
    end : cond_valid

    always_ff @(posedge clk_i) begin : cond_data
        res_q <= zero_out ? '0 : cp.rs1;
    end : cond_data

    assign cp.valid = valid_q;
    assign cp.res   = valid_q ? res_q : '0;

endmodule

`default_nettype wire

//--- src/alu_top.sv
/*
 * integer ALU top level
 * data path, co-processor control, shifter and conditional-zero units
 */
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  alu_op_t             alu_op_i,
    input  logic                unsigned_i,
    input  logic                opa_sel_i,
    input  logic                opb_sel_i,
    input  logic [CP_SLOTS-1:0] cp_trig_i,
    input  cp_funct_t           cp_funct_i,
    input  logic                trap_i,
    input  logic [XLEN-1:0]     rs1_i,
    input  logic [XLEN-1:0]     rs2_i,
    input  logic [XLEN-1:0]     pc_i,
    input  logic [XLEN-1:0]     imm_i,
    output logic [1:0]          cmp_o,
    output logic [XLEN-1:0]     res_o,
    output logic [XLEN-1:0]     add_o,
    output logic                exc_o,
    output logic                cp_done_o
);

    logic [XLEN-1:0] cp_res;              // merged unit result
    logic [XLEN-1:0] cp_opb;              // selected b for the units

    cp_if shift_cp ();
    cp_if cond_cp ();

    alu_core alu_core_inst (
        .alu_op_i   (alu_op_i  ),
        .unsigned_i (unsigned_i),
        .opa_sel_i  (opa_sel_i ),
        .opb_sel_i  (opb_sel_i ),
        .rs1_i      (rs1_i     ),
        .rs2_i      (rs2_i     ),
        .pc_i       (pc_i      ),
        .imm_i      (imm_i     ),
        .cp_res_i   (cp_res    ),
        .cmp_o      (cmp_o     ),
        .opb_o      (cp_opb    ),
        .res_o      (res_o     ),
        .add_o      (add_o     )
    );

    cp_control cp_control_inst (
        .clk_i      (clk_i     ),
        .rstn_i     (rstn_i    ),
        .cp_trig_i  (cp_trig_i ),
        .cp_funct_i (cp_funct_i),
        .trap_i     (trap_i    ),
        .rs1_i      (rs1_i     ),
        .opb_i      (cp_opb    ),
        .shift_cp   (shift_cp  ),
        .cond_cp    (cond_cp   ),
        .cp_res_o   (cp_res    ),
        .cp_done_o  (cp_done_o ),
        .exc_o      (exc_o     )
    );

    cp_shifter cp_shifter_inst (
        .clk_i  (clk_i   ),
        .rstn_i (rstn_i  ),
        .cp     (shift_cp)
    );

    cp_cond cp_cond_inst (
        .clk_i  (clk_i  ),
        .rstn_i (rstn_i ),
        .cp     (cond_cp)
    );

endmodule

`default_nettype wire

//--- test/alu_checker.sv
/*
 * ALU checker
 * compares DUT outputs with expected values, watches the done pulse,
 * counts checks, value errors and other failures
 */
`timescale 1ns/1ps
`default_nettype none

module alu_checker import alu_pkg::*; (
    input  logic            clk_i,
    input  logic [1:0]      cmp_i,        // {lt, eq}
    input  logic [XLEN-1:0] res_i,
    input  logic [XLEN-1:0] add_i,
    input  logic            exc_i,
    input  logic            cp_done_i
);

    int   chk_cnt  = 0;                   // compared values
    int   err_cnt  = 0;                   // wrong values
    int   fail_cnt = 0;                   // timeouts, protocol trouble
    logic done_q   = 1'b0;                // done seen last cycle

    task automatic note_failure(input string msg);
        fail_cnt++;
        $display("%s", msg);
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        chk_cnt++;
        if (act !== exp) begin            // x or z counts as wrong
            err_cnt++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // combinational rows ------------------------
    task automatic compare_comb(input string name, input logic [XLEN-1:0] exp_res,
                                input logic [XLEN-1:0] exp_add, input logic [1:0] exp_cmp);
        compare_word({name, " res_o"}, exp_res, res_i);
        compare_word({name, " add_o"}, exp_add, add_i);
        compare_word({name, " cmp_o"}, {{(XLEN-2){1'b0}}, exp_cmp},
                     {{(XLEN-2){1'b0}}, cmp_i});
    endtask

    // co-processor rows, called in the done cycle
    task automatic compare_cp(input string name, input logic [XLEN-1:0] exp_res,
                              input int exp_lat, input int lat);
        compare_word({name, " res_o"}, exp_res, res_i);
        chk_cnt++;
        if (lat != exp_lat) begin
            err_cnt++;
            $display("error %s latency: expected %0d, actual %0d", name, exp_lat, lat);
        end
        if (exc_i !== 1'b0) begin
            note_failure({name, ": exc_o is high during a normal co-processor run"});
        end
    endtask

    // done must be a single-cycle pulse
    always @(negedge clk_i) begin : done_watch
        if (cp_done_i === 1'b1 && done_q === 1'b1) begin
            note_failure("cp_done_o stayed high for more than one cycle");
        end
        done_q <= cp_done_i;
    end : done_watch

endmodule

`default_nettype wire

//--- test/tb_alu.sv
/*
 * ALU testbench top
 * clock, reset, stimulus table with expected values, driving loop
 * and the co-processor timeout scenario
 */
`timescale 1ns/1ps
`default_nettype none

module tb_alu import alu_pkg::*; ();

    localparam int SEED      = 10526;
    localparam int CP_WAIT   = 100;       // cycles allowed for a done pulse
    localparam int EXC_WAIT  = 100;       // cycles allowed for the timeout
    localparam int CLR_WAIT  = 2;         // trap stops the monitor, exc_o falls one edge later
    localparam logic [CP_SLOTS-1:0] TRIG_SH = CP_SLOTS'(1 << CP_SEL_SHIFT);
    localparam logic [CP_SLOTS-1:0] TRIG_CD = CP_SLOTS'(1 << CP_SEL_COND);
    localparam logic [CP_SLOTS-1:0] TRIG_RS = CP_SLOTS'(1 << CP_SEL_RSVD);

    typedef struct {
        string               name;
        alu_op_t             op;
        logic                uns;
        logic                asel;        // 1: pc
        logic                bsel;        // 1: imm
        logic [CP_SLOTS-1:0] trig;        // zero for plain ALU rows
        cp_funct_t           funct;
        logic [XLEN-1:0]     rs1;
        logic [XLEN-1:0]     rs2;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     imm;
        logic [XLEN-1:0]     exp;         // expected res_o
    } row_t;

    row_t rows[$];                        // stimulus table

    logic                clk;
    logic                rstn;
    alu_op_t             alu_op;
    logic                uns;
    logic                opa_sel;
    logic                opb_sel;
    logic [CP_SLOTS-1:0] cp_trig;
    cp_funct_t           cp_funct;
    logic                trap;
    logic [XLEN-1:0]     rs1;
    logic [XLEN-1:0]     rs2;
    logic [XLEN-1:0]     pc;
    logic [XLEN-1:0]     imm;
    logic [1:0]          cmp;
    logic [XLEN-1:0]     res;
    logic [XLEN-1:0]     add;
    logic                exc;
    logic                cp_done;

    always #5 clk = ~clk;                 // 10 ns period

    alu_top alu_top_inst (
        .clk_i      (clk     ),
        .rstn_i     (rstn    ),
        .alu_op_i   (alu_op  ),
        .unsigned_i (uns     ),
        .opa_sel_i  (opa_sel ),
        .opb_sel_i  (opb_sel ),
        .cp_trig_i  (cp_trig ),
        .cp_funct_i (cp_funct),
        .trap_i     (trap    ),
        .rs1_i      (rs1     ),
        .rs2_i      (rs2     ),
        .pc_i       (pc      ),
        .imm_i      (imm     ),
        .cmp_o      (cmp     ),
        .res_o      (res     ),
        .add_o      (add     ),
        .exc_o      (exc     ),
        .cp_done_o  (cp_done )
    );

    alu_checker alu_checker_inst (
        .clk_i      (clk    ),
        .cmp_i      (cmp    ),
        .res_i      (res    ),
        .add_i      (add    ),
        .exc_i      (exc    ),
        .cp_done_i  (cp_done)
    );

    // reference rules ---------------------------
    function automatic logic [XLEN-1:0] expect_result(input alu_op_t op, input logic u,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] r1);
        logic lt;
        lt = u ? (a < b) : ($signed(a) < $signed(b));
        case (op)
            ALU_OP_SUB  : return a - b;
            ALU_OP_SLT  : return {{(XLEN-1){1'b0}}, lt};
            ALU_OP_MOVB : return b;
            ALU_OP_XOR  : return r1 ^ b;        // logic ops always use rs1
            ALU_OP_OR   : return r1 | b;
            ALU_OP_AND  : return r1 & b;
            default     : return a + b;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expect_add(input alu_op_t op,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        return op[0] ? a - b : a + b;           // bit 0 selects subtract
    endfunction

    function automatic logic [1:0] expect_cmp(input logic u, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b);
        logic [1:0] c;
        c[CMP_EQ] = (a == b);
        c[CMP_LT] = u ? (a < b) : ($signed(a) < $signed(b));
        return c;
    endfunction

    function automatic logic [XLEN-1:0] expect_shift(input cp_funct_t f,
            input logic [XLEN-1:0] v, input logic [SHAMT_W-1:0] sh);
        case (f)
            CP_SLL  : return v << sh;
            CP_SRL  : return v >> sh;
            default : return $unsigned($signed(v) >>> sh);
        endcase
    endfunction

    // table building ----------------------------
    task automatic add_alu(input string name, input alu_op_t op, input logic u,
                           input logic asel, input logic bsel, input logic [XLEN-1:0] a1,
                           input logic [XLEN-1:0] a2, input logic [XLEN-1:0] p,
                           input logic [XLEN-1:0] im, input logic [XLEN-1:0] exp);
        row_t r;
        r.name  = name;
        r.op    = op;
        r.uns   = u;
        r.asel  = asel;
        r.bsel  = bsel;
        r.trig  = '0;
        r.funct = CP_SLL;
        r.rs1   = a1;
        r.rs2   = a2;
        r.pc    = p;
        r.imm   = im;
        r.exp   = exp;
        rows.push_back(r);
    endtask

    task automatic add_cp(input string name, input logic [CP_SLOTS-1:0] trig,
                          input cp_funct_t f, input logic [XLEN-1:0] a1,
                          input logic [XLEN-1:0] a2, input logic [XLEN-1:0] exp);
        row_t r;
        r.name  = name;
        r.op    = ALU_OP_CP;
        r.uns   = 1'b0;
        r.asel  = 1'b0;
        r.bsel  = 1'b0;                   // operand b is rs2
        r.trig  = trig;
        r.funct = f;
        r.rs1   = a1;
        r.rs2   = a2;
        r.pc    = '0;
        r.imm   = '0;
        r.exp   = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        alu_op_t         ops [7] = '{ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLT, ALU_OP_MOVB,
                                     ALU_OP_XOR, ALU_OP_OR, ALU_OP_AND};
        cp_funct_t       shf [3] = '{CP_SLL, CP_SRL, CP_SRA};
        alu_op_t         op;
        cp_funct_t       f;
        logic            u;
        logic            asel;
        logic            bsel;
        logic [XLEN-1:0] a1;
        logic [XLEN-1:0] a2;
        logic [XLEN-1:0] p;
        logic [XLEN-1:0] im;
        // add, sub and address
        add_alu("add_rs", ALU_OP_ADD, 1'b0, 1'b0, 1'b0,
                32'h5, 32'h7, 32'h0, 32'h0, 32'hC);
        add_alu("add_pc_imm", ALU_OP_ADD, 1'b0, 1'b1, 1'b1,
                32'h0, 32'h0, 32'h1000, 32'hFFFF_FFFC, 32'h0000_0FFC);
        add_alu("sub_rs1_imm", ALU_OP_SUB, 1'b0, 1'b0, 1'b1,
                32'h10, 32'h3, 32'h0, 32'h20, 32'hFFFF_FFF0);
        add_alu("add_wrap", ALU_OP_ADD, 1'b0, 1'b0, 1'b0,
                32'hFFFF_FFFF, 32'h1, 32'h0, 32'h0, 32'h0);
        // comparator and slt at the corners
        add_alu("slt_min", ALU_OP_SLT, 1'b0, 1'b0, 1'b0,
                32'h8000_0000, 32'h1, 32'h0, 32'h0, 32'h1);
        add_alu("sltu_min", ALU_OP_SLT, 1'b1, 1'b0, 1'b0,
                32'h8000_0000, 32'h1, 32'h0, 32'h0, 32'h0);
        add_alu("slt_neg1", ALU_OP_SLT, 1'b0, 1'b0, 1'b0,
                32'hFFFF_FFFF, 32'h0, 32'h0, 32'h0, 32'h1);
        add_alu("sltu_neg1", ALU_OP_SLT, 1'b1, 1'b0, 1'b0,
                32'hFFFF_FFFF, 32'h0, 32'h0, 32'h0, 32'h0);
        add_alu("sltu_max", ALU_OP_SLT, 1'b1, 1'b0, 1'b0,
                32'h0, 32'hFFFF_FFFF, 32'h0, 32'h0, 32'h1);
        add_alu("slt_equal", ALU_OP_SLT, 1'b0, 1'b0, 1'b0,
                32'h8000_0000, 32'h8000_0000, 32'h0, 32'h0, 32'h0);
        // logic ops and move
        add_alu("movb_imm", ALU_OP_MOVB, 1'b0, 1'b0, 1'b1,
                32'h0, 32'h0, 32'h0, 32'h1234_5678, 32'h1234_5678);
        add_alu("xor_rs", ALU_OP_XOR, 1'b0, 1'b0, 1'b0,
                32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 32'h0, 32'h0FF0_0FF0);
        add_alu("or_rs", ALU_OP_OR, 1'b0, 1'b0, 1'b0,
                32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 32'h0, 32'hFFF0_FFF0);
        add_alu("and_rs", ALU_OP_AND, 1'b0, 1'b0, 1'b0,
                32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 32'h0, 32'hF000_F000);
        // shifter edges with shamt from the low 5 bits of rs2
        add_cp("sll_0", TRIG_SH, CP_SLL, 32'h8000_0001, 32'h0, 32'h8000_0001);
        add_cp("sll_1", TRIG_SH, CP_SLL, 32'h8000_0001, 32'h1, 32'h0000_0002);
        add_cp("sll_31", TRIG_SH, CP_SLL, 32'h1, 32'h1F, 32'h8000_0000);
        add_cp("sll_low5", TRIG_SH, CP_SLL, 32'h1, 32'h21, 32'h2);
        add_cp("srl_1", TRIG_SH, CP_SRL, 32'h8000_0002, 32'h1, 32'h4000_0001);
        add_cp("srl_31", TRIG_SH, CP_SRL, 32'h8000_0000, 32'h1F, 32'h1);
        add_cp("sra_0", TRIG_SH, CP_SRA, 32'h8000_0000, 32'h0, 32'h8000_0000);
        add_cp("sra_1", TRIG_SH, CP_SRA, 32'h8000_0002, 32'h1, 32'hC000_0001);
        add_cp("sra_31", TRIG_SH, CP_SRA, 32'h8000_0000, 32'h1F, 32'hFFFF_FFFF);
        // conditional zero
        add_cp("czero_eqz_z", TRIG_CD, CP_CZERO_EQZ, 32'h1234_5678, 32'h0, 32'h0);
        add_cp("czero_eqz_nz", TRIG_CD, CP_CZERO_EQZ, 32'h1234_5678, 32'h5, 32'h1234_5678);
        add_cp("czero_nez_z", TRIG_CD, CP_CZERO_NEZ, 32'h1234_5678, 32'h0, 32'h1234_5678);
        add_cp("czero_nez_nz", TRIG_CD, CP_CZERO_NEZ, 32'h1234_5678, 32'h5, 32'h0);
        // random rows
        for (int i = 0; i < 24; i++) begin
            op   = ops[$urandom_range(6, 0)];
            u    = 1'($urandom);
            asel = 1'($urandom);
            bsel = 1'($urandom);
            a1   = $urandom;
            a2   = (i % 6 == 0) ? a1 : $urandom;   // some equal operands
            p    = $urandom;
            im   = $urandom;
            add_alu($sformatf("rand_alu_%0d", i), op, u, asel, bsel, a1, a2, p, im,
                    expect_result(op, u, asel ? p : a1, bsel ? im : a2, a1));
        end
        for (int i = 0; i < 8; i++) begin
            f  = shf[$urandom_range(2, 0)];
            a1 = $urandom;
            a2 = $urandom;
            add_cp($sformatf("rand_shift_%0d", i), TRIG_SH, f, a1, a2,
                   expect_shift(f, a1, a2[SHAMT_W-1:0]));
        end
        // timeout followed by a normal shift
        add_cp("rsvd_timeout", TRIG_RS, CP_SLL, 32'h1, 32'h2, 32'h0);
        add_cp("sll_after_trap", TRIG_SH, CP_SLL, 32'h0000_00FF, 32'h4, 32'h0000_0FF0);
    endtask

    // driving -----------------------------------
    task automatic wait_done(input row_t r, input logic [XLEN-1:0] b);
        int   cyc;
        int   exp_lat;
        logic seen;
        cyc     = 0;
        seen    = 1'b0;
        exp_lat = r.trig[CP_SEL_SHIFT] ? int'(b[SHAMT_W-1:0]) + 1 : 1;
        while (!seen && cyc < CP_WAIT) begin
            @(posedge clk);
            #1;
            cp_trig = '0;                 // start is a single pulse
            @(negedge clk);
            cyc++;
            seen = (cp_done === 1'b1);
        end
        if (seen) begin
            alu_checker_inst.compare_cp(r.name, r.exp, exp_lat, cyc);
        end else begin
            alu_checker_inst.note_failure($sformatf("%s: no cp_done_o within %0d cycles",
                                                    r.name, CP_WAIT));
        end
        repeat (2) @(posedge clk);        // monitor back to idle
    endtask

    task automatic run_timeout();
        int   cyc;
        logic seen;
        cyc  = 0;
        seen = 1'b0;
        while (!seen && cyc < EXC_WAIT) begin
            @(posedge clk);
            #1;
            cp_trig = '0;
            @(negedge clk);
            cyc++;
            if (cp_done === 1'b1) begin
                alu_checker_inst.note_failure("cp_done_o pulsed for the reserved slot");
            end
            seen = (exc === 1'b1);
        end
        if (!seen) begin
            alu_checker_inst.note_failure("exc_o did not rise after a reserved trigger");
        end else begin
            @(posedge clk);
            #1;
            trap = 1'b1;                  // trap right away before the counter wraps
            @(posedge clk);
            #1;
            trap = 1'b0;
            cyc  = 0;
            while (seen && cyc < CLR_WAIT) begin
                @(negedge clk);
                cyc++;
                seen = (exc !== 1'b0);
            end
            if (seen) begin
                alu_checker_inst.note_failure("exc_o stayed high after the trap");
            end
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic apply_row(input row_t r);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = r.asel ? r.pc : r.rs1;
        b = r.bsel ? r.imm : r.rs2;
        @(posedge clk);
        #1;
        alu_op   = r.op;
        uns      = r.uns;
        opa_sel  = r.asel;
        opb_sel  = r.bsel;
        cp_trig  = r.trig;
        cp_funct = r.funct;
        rs1      = r.rs1;
        rs2      = r.rs2;
        pc       = r.pc;
        imm      = r.imm;
        if (r.trig[CP_SEL_RSVD]) begin
            run_timeout();
        end else if (r.trig != '0) begin
            wait_done(r, b);
        end else begin
            @(negedge clk);               // outputs settled mid cycle
            alu_checker_inst.compare_comb(r.name, r.exp, expect_add(r.op, a, b),
                                          expect_cmp(r.uns, r.rs1, r.rs2));
        end
    endtask

    initial begin : main
        clk      = 1'b0;
        rstn     = 1'b0;
        alu_op   = ALU_OP_ADD;
        uns      = 1'b0;
        opa_sel  = 1'b0;
        opb_sel  = 1'b0;
        cp_trig  = '0;
        cp_funct = CP_SLL;
        trap     = 1'b0;
        rs1      = '0;
        rs2      = '0;
        pc       = '0;
        imm      = '0;
        void'($urandom(SEED));
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, value errors %0d, other failures %0d",
                 alu_checker_inst.chk_cnt, alu_checker_inst.err_cnt,
                 alu_checker_inst.fail_cnt);
        if (alu_checker_inst.err_cnt == 0 && alu_checker_inst.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end : main

endmodule

`default_nettype wire

//--- flist.f
common/alu_pkg.sv
common/cp_if.sv
adder/prefix_adder.sv
src/alu_core.sv
coproc/cp_control.sv
coproc/cp_shifter.sv
coproc/cp_cond.sv
src/alu_top.sv
test/alu_checker.sv
test/tb_alu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_alu -Mdir obj_dir -o tb_alu_sim
./obj_dir/tb_alu_sim > sim.log
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
